//--- Bender.yml
package:
  name: gpio

sources:
  - src/gpio_pkg.sv
  - src/gpio_pin_if.sv
  - src/gpio_regs.sv
  - src/gpio_pad_bank.sv
  - src/gpio_in_sync.sv
  - src/gpio_top.sv
  - target: simulation
    files:
      - dv/gpio_props.sv
      - dv/gpio_tb.sv

//--- dv/gpio_patterns.txt
# Columns: test name, op, register offset or pin mask (hex), value (hex)
# Ops: W write, R read and compare, H host enable/value, P pads under mask, I intr_o
rst_data_out     R 0    00000000
rst_intr_state   R 5    00000000
rst_irq          I 0    00000000
wr_data_out      W 0    ffffabcd
rd_data_out      R 0    0000abcd
wr_pull_sel      W 3    12345678
rd_pull_sel      R 3    00005678
rd_unmapped      R f    00000000
wr_data_in       W 4    0000ffff
rd_data_in_ro    R 4    00000000
dev_out_en       W 1    0000ffff
dev_pad          P ffff 0000abcd
dev_host_fight   H 00ff 00000000
dev_pad_wins     P ffff 0000abcd
rd_contention    R 8    000000ff
host_release     H 0000 00000000
clr_cont_part    W 8    000000f0
rd_cont_part     R 8    0000000f
clr_cont_all     W 8    ffffffff
rd_cont_none     R 8    00000000
dev_off          W 1    00000000
keep_dev_level   P ffff 0000abcd
host_drive       H ffff 00001234
host_pad         P ffff 00001234
pull_on          W 2    0000ffff
host_over_pull   P ffff 00001234
host_off         H 0000 00000000
pull_pad         P ffff 00005678
pull_sel_chg     W 3    0000a5a5
pull_pad_new     P ffff 0000a5a5
pull_off         W 2    00000000
keep_pull_level  P ffff 0000a5a5
in_settled       R 4    0000a5a5
in_host_step     H ffff 0000f00f
in_pad_step      P ffff 0000f00f
in_not_yet       R 4    0000a5a5
in_followed      R 4    0000f00f
irq_clear_all    W 5    ffffffff
rd_irq_cleared   R 5    00000000
irq_idle         I 0    00000000
rise_en_b4       W 6    00000010
rise_step        H ffff 0000f01f
rise_pad         P ffff 0000f01f
rise_wait_1      I 0    00000000
rise_wait_2      I 0    00000000
rise_irq         I 0    00000001
rd_rise_state    R 5    00000010
rise_clear       W 5    00000010
rise_irq_low     I 0    00000000
rise_en_off      W 6    00000000
fall_step        H ffff 0000f00f
fall_pad         P ffff 0000f00f
fall_wait_1      I 0    00000000
fall_wait_2      I 0    00000000
rd_fall_state    R 5    00000010
fall_masked      I 0    00000000
fall_en_b4       W 7    00000010
fall_irq         I 0    00000001
fall_clear       W 5    00000010
fall_irq_low     I 0    00000000
rd_irq_end       R 5    00000000

//--- dv/gpio_props.sv
/*
 * Pad bank checks, bound into every gpio_pad_bank instance.
 * Each check covers the whole pin vector, so a failure does not name the pin.
 */
`default_nettype none

module gpio_props #(
  parameter int NGpio = 16
) (
  input logic             clk_i,
  input logic             rst_ni,
  input logic [NGpio-1:0] host_en,
  input logic [NGpio-1:0] d2p,
  input logic [NGpio-1:0] en_d2p,
  input logic [NGpio-1:0] pull_en,
  input logic [NGpio-1:0] pull_sel,
  input logic [NGpio-1:0] p2d,
  input logic [NGpio-1:0] contention
);
  timeunit 1ns;
  timeprecision 1ps;

  // Device driven pins show last cycle's output value
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((p2d ^ $past(d2p)) & $past(en_d2p)) == '0)
    else $error("Driven pad does not follow d2p");

  // With no device or host drive a pulled pin takes the pull level
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((p2d ^ $past(pull_sel)) & $past(pull_en & ~en_d2p & ~host_en)) == '0)
    else $error("Pulled pad does not match pull_sel");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (contention & ~$past(en_d2p & host_en)) == '0)
    else $error("Contention flagged without both drivers enabled");

endmodule

bind gpio_pad_bank gpio_props #(.NGpio(NGpio)) u_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .host_en    (host_en),
  .d2p        (pins.d2p),
  .en_d2p     (pins.en_d2p),
  .pull_en    (pins.pull_en),
  .pull_sel   (pins.pull_sel),
  .p2d        (pins.p2d),
  .contention (contention)
);

`default_nettype wire

//--- dv/gpio_tb.sv
/*
 * Testbench for gpio_top, driven line by line from dv/gpio_patterns.txt.
 * Built for the default of 16 pins; the run stops at the first error.
 */
`default_nettype none

module gpio_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NGpio = 16;
  localparam string PatternFile = "dv/gpio_patterns.txt";

  logic                clk_i;
  logic                rst_ni;
  logic                we;
  logic                re;
  gpio_pkg::reg_addr_t addr;
  gpio_pkg::reg_data_t wdata;
  logic [NGpio-1:0]    host_val;
  logic [NGpio-1:0]    host_en;
  gpio_pkg::reg_data_t rdata;
  logic                rvalid;
  logic                intr_o;
  logic [NGpio-1:0]    pad_o;

  string       name_q[$];  // One entry per pattern line
  string       op_q[$];
  logic [31:0] arg_q[$];   // Register offset or pin mask
  logic [31:0] val_q[$];

  int cycle_cnt;
  int cycle_limit;

  gpio_top #(.NGpio(NGpio)) u_gpio_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .we       (we),
    .re       (re),
    .addr     (addr),
    .wdata    (wdata),
    .host_val (host_val),
    .host_en  (host_en),
    .rdata    (rdata),
    .rvalid   (rvalid),
    .intr_o   (intr_o),
    .pad_o    (pad_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input gpio_pkg::reg_data_t exp,
                            input gpio_pkg::reg_data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_pad(input string name, input logic [NGpio-1:0] exp,
                           input logic [NGpio-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    end
  endtask

  // The register takes the data on the second edge
  task automatic bus_write(input gpio_pkg::reg_addr_t a, input gpio_pkg::reg_data_t d);
    @(posedge clk_i);
    we    <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge clk_i);
    we    <= 1'b0;
  endtask

  task automatic bus_read(input string name, input gpio_pkg::reg_addr_t a,
                          input gpio_pkg::reg_data_t exp);
    @(posedge clk_i);
    re   <= 1'b1;
    addr <= a;
    @(posedge clk_i);
    re   <= 1'b0;
    @(negedge clk_i);  // rdata and rvalid settle after the capture edge
    if (rvalid !== 1'b1) begin
      stop_on_error($sformatf("Read %s at offset %0h returned no rvalid", name, a));
    end
    check_data(name, exp, rdata);
  endtask

  task automatic host_drive(input logic [NGpio-1:0] mask, input logic [NGpio-1:0] val);
    @(posedge clk_i);
    host_en  <= mask;
    host_val <= val;
  endtask

  initial begin
    int          fd;
    int          code;
    string       tok;
    string       op;
    string       rest;
    logic [31:0] arg;
    logic [31:0] val;

    rst_ni    = 1'b0;
    we        = 1'b0;
    re        = 1'b0;
    addr      = '0;
    wdata     = '0;
    host_val  = '0;
    host_en   = '0;
    cycle_cnt = 0;

    fd = $fopen(PatternFile, "r");
    if (fd == 0) begin
      stop_on_error("Cannot open the pattern file dv/gpio_patterns.txt");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok.getc(0) == "#") begin
        code = $fgets(rest, fd);  // Skip the rest of a comment line
      end else begin
        code = $fscanf(fd, "%s %h %h", op, arg, val);
        if (code != 3) begin
          stop_on_error($sformatf("Pattern line %s has missing fields", tok));
        end
        name_q.push_back(tok);
        op_q.push_back(op);
        arg_q.push_back(arg);
        val_q.push_back(val);
      end
    end
    $fclose(fd);
    cycle_limit = 20 * name_q.size() + 100;

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    foreach (name_q[i]) begin
      case (op_q[i])
        "W": bus_write(arg_q[i][3:0], val_q[i]);
        "R": bus_read(name_q[i], arg_q[i][3:0], val_q[i]);
        "H": host_drive(arg_q[i][NGpio-1:0], val_q[i][NGpio-1:0]);
        "P": begin
          @(posedge clk_i);
          @(negedge clk_i);
          check_pad(name_q[i], val_q[i][NGpio-1:0] & arg_q[i][NGpio-1:0],
                    pad_o & arg_q[i][NGpio-1:0]);
        end
        "I": begin
          @(posedge clk_i);
          @(negedge clk_i);
          check_irq(name_q[i], val_q[i][0], intr_o);
        end
        default: stop_on_error($sformatf("Unknown op %s in pattern %s", op_q[i], name_q[i]));
      endcase
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

  // Each pattern line needs only a few cycles
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      stop_on_error($sformatf("Timeout, the run went past %0d cycles", cycle_limit));
    end
  end

endmodule

`default_nettype wire

//--- list.f
src/gpio_pkg.sv
src/gpio_pin_if.sv
src/gpio_regs.sv
src/gpio_pad_bank.sv
src/gpio_in_sync.sv
src/gpio_top.sv
dv/gpio_props.sv
dv/gpio_tb.sv

//--- src/gpio_in_sync.sv
/*
 * Two-flop synchronizer on the resolved pins, then edge detection.
 * Levels and edge pulses appear two cycles after the pad changes.
 */
`default_nettype none

module gpio_in_sync #(
  parameter int NGpio = 16
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  gpio_pin_if.sense        pins,
  output logic [NGpio-1:0] pin_in,
  output logic [NGpio-1:0] rise,
  output logic [NGpio-1:0] fall
);

  logic [NGpio-1:0] sync_q1;  // First stage, may be metastable on real pads
  logic [NGpio-1:0] sync_q2;  // Settled level
  logic [NGpio-1:0] prev_q;   // Settled level one cycle back

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pins.p2d;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_q <= '0;
    end else begin
      prev_q <= sync_q2;
    end
  end

  // Pulses last one cycle since prev_q catches up on the next edge
  assign rise   =  sync_q2 & ~prev_q;
  assign fall   = ~sync_q2 &  prev_q;
  assign pin_in = sync_q2;

endmodule

`default_nettype wire

//--- src/gpio_pad_bank.sv
/*
 * Behavioral pad model with a registered pin level that resets to zero.
 * Priority per pin is device drive, host drive, pull, then the bus keeper.
 */
`default_nettype none

module gpio_pad_bank #(
  parameter int NGpio = 16
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [NGpio-1:0] host_val,
  input  logic [NGpio-1:0] host_en,
  output logic [NGpio-1:0] contention,
  gpio_pin_if.pad          pins
);

  logic [NGpio-1:0] p2d_d;
  logic [NGpio-1:0] contention_d;

  // Resolve every pin on its own
  always_comb begin
    for (int i = 0; i < NGpio; i++) begin
      if (pins.en_d2p[i]) begin
        p2d_d[i] = pins.d2p[i];       // The device wins over the host
      end else if (host_en[i]) begin
        p2d_d[i] = host_val[i];
      end else if (pins.pull_en[i]) begin
        p2d_d[i] = pins.pull_sel[i];
      end else begin
        p2d_d[i] = pins.p2d[i];       // Nobody drives, the keeper holds the level
      end
    end
  end

  // Both sides drive the pin in this cycle
  assign contention_d = pins.en_d2p & host_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pins.p2d <= '0;
    end else begin
      pins.p2d <= p2d_d;
    end
  end

  // One pulse per cycle of overlap, the register file makes it sticky
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      contention <= '0;
    end else begin
      contention <= contention_d;
    end
  end

endmodule

`default_nettype wire

//--- src/gpio_pin_if.sv
/*
 * Device side pad controls and the resolved pin levels.
 * Carries no clock; every consumer registers on its own clock.
 */
`default_nettype none

interface gpio_pin_if #(
  parameter int NGpio = 16
);

  logic [NGpio-1:0] d2p;       // Device output value
  logic [NGpio-1:0] en_d2p;    // Device output enable
  logic [NGpio-1:0] pull_en;   // Pull enable
  logic [NGpio-1:0] pull_sel;  // Pull level when enabled
  logic [NGpio-1:0] p2d;       // Resolved pin level from the pads

  // Register file side, owns the pad controls
  modport ctrl (
    output d2p,
    output en_d2p,
    output pull_en,
    output pull_sel
  );

  // Pad bank side, resolves the pins
  modport pad (
    input  d2p,
    input  en_d2p,
    input  pull_en,
    input  pull_sel,
    output p2d
  );

  // Input path only observes the resolved levels
  modport sense (
    input p2d
  );

endinterface

`default_nettype wire

//--- src/gpio_pkg.sv
/*
 * Shared bus types and register word offsets of the GPIO block.
 * Pins fill the low bits of a data word; bits above the pin count read as zero.
 */
`default_nettype none

package gpio_pkg;

  localparam int AddrWidth = 4;   // Word offsets 0 to 15, nine are decoded
  localparam int DataWidth = 32;  // Also the upper limit for the pin count

  typedef logic [AddrWidth-1:0] reg_addr_t;
  typedef logic [DataWidth-1:0] reg_data_t;

  // Control registers, read/write
  localparam reg_addr_t ADDR_DATA_OUT     = 4'd0;  // Device output value
  localparam reg_addr_t ADDR_OUT_EN       = 4'd1;  // Device output enable
  localparam reg_addr_t ADDR_PULL_EN      = 4'd2;  // Pull enable per pin
  localparam reg_addr_t ADDR_PULL_SEL     = 4'd3;  // Pull level, 1 pulls up

  // Synchronized pin levels, writes are ignored
  localparam reg_addr_t ADDR_DATA_IN      = 4'd4;

  // Interrupt status and enables
  localparam reg_addr_t ADDR_INTR_STATE   = 4'd5;  // Write 1 to clear
  localparam reg_addr_t ADDR_INTR_RISE_EN = 4'd6;
  localparam reg_addr_t ADDR_INTR_FALL_EN = 4'd7;

  // Sticky flag per pin where device and host drove at the same time
  localparam reg_addr_t ADDR_CONTENTION   = 4'd8;  // Write 1 to clear

endpackage

`default_nettype wire

//--- src/gpio_regs.sv
/*
 * Register file on a plain write/read strobe bus, reads return one cycle later.
 * Status bits are write-1-to-clear; a new event in the same cycle wins over the clear.
 */
`default_nettype none

module gpio_regs #(
  parameter int NGpio = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                we,
  input  logic                re,
  input  gpio_pkg::reg_addr_t addr,
  input  gpio_pkg::reg_data_t wdata,
  input  logic [NGpio-1:0]    pin_in,
  input  logic [NGpio-1:0]    rise,
  input  logic [NGpio-1:0]    fall,
  input  logic [NGpio-1:0]    contention,
  output gpio_pkg::reg_data_t rdata,
  output logic                rvalid,
  output logic                intr,
  gpio_pin_if.ctrl            pins
);

  logic [NGpio-1:0] data_out_q;
  logic [NGpio-1:0] out_en_q;
  logic [NGpio-1:0] pull_en_q;
  logic [NGpio-1:0] pull_sel_q;
  logic [NGpio-1:0] intr_state_q;
  logic [NGpio-1:0] intr_rise_en_q;
  logic [NGpio-1:0] intr_fall_en_q;
  logic [NGpio-1:0] contention_q;

  logic [NGpio-1:0] wr_bits;    // Bus data cut to the pin count
  logic [NGpio-1:0] read_bits;  // Selected register before zero extension
  gpio_pkg::reg_data_t rdata_d;

  assign wr_bits = wdata[NGpio-1:0];

  // Control registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_out_q     <= '0;
      out_en_q       <= '0;
      pull_en_q      <= '0;
      pull_sel_q     <= '0;
      intr_rise_en_q <= '0;
      intr_fall_en_q <= '0;
    end else if (we) begin
      case (addr)
        gpio_pkg::ADDR_DATA_OUT:     data_out_q     <= wr_bits;
        gpio_pkg::ADDR_OUT_EN:       out_en_q       <= wr_bits;
        gpio_pkg::ADDR_PULL_EN:      pull_en_q      <= wr_bits;
        gpio_pkg::ADDR_PULL_SEL:     pull_sel_q     <= wr_bits;
        gpio_pkg::ADDR_INTR_RISE_EN: intr_rise_en_q <= wr_bits;
        gpio_pkg::ADDR_INTR_FALL_EN: intr_fall_en_q <= wr_bits;
        default: ;                                   // Read-only and status offsets
      endcase
    end
  end

  // Every edge is recorded, the enables only gate the interrupt line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_state_q <= '0;
    end else if (we && addr == gpio_pkg::ADDR_INTR_STATE) begin
      intr_state_q <= (intr_state_q & ~wr_bits) | rise | fall;
    end else begin
      intr_state_q <= intr_state_q | rise | fall;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      contention_q <= '0;
    end else if (we && addr == gpio_pkg::ADDR_CONTENTION) begin
      contention_q <= (contention_q & ~wr_bits) | contention;
    end else begin
      contention_q <= contention_q | contention;
    end
  end

  // Read mux, unused offsets return zero
  always_comb begin
    case (addr)
      gpio_pkg::ADDR_DATA_OUT:     read_bits = data_out_q;
      gpio_pkg::ADDR_OUT_EN:       read_bits = out_en_q;
      gpio_pkg::ADDR_PULL_EN:      read_bits = pull_en_q;
      gpio_pkg::ADDR_PULL_SEL:     read_bits = pull_sel_q;
      gpio_pkg::ADDR_DATA_IN:      read_bits = pin_in;  // Already two flops behind the pad
      gpio_pkg::ADDR_INTR_STATE:   read_bits = intr_state_q;
      gpio_pkg::ADDR_INTR_RISE_EN: read_bits = intr_rise_en_q;
      gpio_pkg::ADDR_INTR_FALL_EN: read_bits = intr_fall_en_q;
      gpio_pkg::ADDR_CONTENTION:   read_bits = contention_q;
      default:                     read_bits = '0;
    endcase
    rdata_d             = '0;
    rdata_d[NGpio-1:0]  = read_bits;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata  <= '0;
      rvalid <= 1'b0;
    end else begin
      rvalid <= re;
      if (re) begin
        rdata <= rdata_d;  // Held until the next read
      end
    end
  end

  // A pending bit raises the line when either enable of its pin is set
  assign intr = |(intr_state_q & (intr_rise_en_q | intr_fall_en_q));

  assign pins.d2p      = data_out_q;
  assign pins.en_d2p   = out_en_q;
  assign pins.pull_en  = pull_en_q;
  assign pins.pull_sel = pull_sel_q;

endmodule

`default_nettype wire

//--- src/gpio_top.sv
/*
 * GPIO block with a behavioral pad model; the host side drives the pins directly.
 * NGpio may range from 1 to 32.
 */
`default_nettype none

module gpio_top #(
  parameter int NGpio = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                we,
  input  logic                re,
  input  gpio_pkg::reg_addr_t addr,
  input  gpio_pkg::reg_data_t wdata,
  input  logic [NGpio-1:0]    host_val,
  input  logic [NGpio-1:0]    host_en,
  output gpio_pkg::reg_data_t rdata,
  output logic                rvalid,
  output logic                intr_o,
  output logic [NGpio-1:0]    pad_o
);

  logic [NGpio-1:0] pin_in;
  logic [NGpio-1:0] rise;
  logic [NGpio-1:0] fall;
  logic [NGpio-1:0] contention;

  gpio_pin_if #(.NGpio(NGpio)) pins ();

  gpio_regs #(.NGpio(NGpio)) u_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .we         (we),
    .re         (re),
    .addr       (addr),
    .wdata      (wdata),
    .pin_in     (pin_in),
    .rise       (rise),
    .fall       (fall),
    .contention (contention),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .intr       (intr_o),
    .pins       (pins.ctrl)
  );

  gpio_pad_bank #(.NGpio(NGpio)) u_pad_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .host_val   (host_val),
    .host_en    (host_en),
    .contention (contention),
    .pins       (pins.pad)
  );

  gpio_in_sync #(.NGpio(NGpio)) u_in_sync (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .pins   (pins.sense),
    .pin_in (pin_in),
    .rise   (rise),
    .fall   (fall)
  );

  assign pad_o = pins.p2d;  // Resolved levels as seen on the pads

endmodule

`default_nettype wire
